/* nn_pkg.sv */
package nn_pkg;

    // layer dimensions
    localparam int NUM_NEURON = 4;                          // neurons in this layer
    localparam int NUM_INPUTS = 5;                          // inputs feeding each neuron

    // fixed-point formats, all signed two's complement
    localparam int INPUT_SIZE      = 9;                     // input width
    localparam int INPUT_FRACTION  = 8;                     // input bits below the radix point
    localparam int WEIGHT_SIZE     = 17;                    // weight width
    localparam int WEIGHT_FRACTION = 8;                     // weight bits below the radix point
    localparam int OUTPUT_SIZE     = 10;                    // output width
    localparam int FRACTION_BITS   = 7;                     // output bits below the radix point

    // a single product needs INPUT_SIZE + WEIGHT_SIZE = 26 bits, five of them need 29
    localparam int ACC_SIZE = 29;

    // right shift that brings the product fraction down to the output fraction
    localparam int SHIFT = INPUT_FRACTION + WEIGHT_FRACTION - FRACTION_BITS;

    // saturation limits of the signed output range
    localparam int OUT_MAX = 2 ** (OUTPUT_SIZE - 1) - 1;    // 511
    localparam int OUT_MIN = -(2 ** (OUTPUT_SIZE - 1));     // -512

    // weight store geometry
    localparam int NUM_WEIGHTS        = NUM_NEURON * NUM_INPUTS; // weight k of neuron n at n*5+k
    localparam int WADDR_SIZE         = 5;                       // covers all 20 weights
    localparam int NEURON_WEIGHT_BITS = NUM_INPUTS * WEIGHT_SIZE; // one neuron's slice
    localparam int WEIGHT_BUS_SIZE    = NUM_WEIGHTS * WEIGHT_SIZE; // flat vector of all weights

    localparam int IDX_SIZE = 3;                            // wide enough to count the inputs

    typedef logic signed [INPUT_SIZE-1:0]  input_t;
    typedef logic signed [WEIGHT_SIZE-1:0] weight_t;
    typedef logic signed [OUTPUT_SIZE-1:0] out_t;
    typedef logic signed [ACC_SIZE-1:0]    acc_t;

    typedef logic [NUM_NEURON-1:0] neuron_mask_t;           // one bit per neuron
    typedef logic [WADDR_SIZE-1:0] weight_addr_t;
    typedef logic [IDX_SIZE-1:0]   input_idx_t;

    localparam input_idx_t LAST_IDX = input_idx_t'(NUM_INPUTS - 1); // final accumulate step

    // layer sequencer
    typedef enum logic [1:0] {
        L_IDLE,
        L_RUN,
        L_DONE
    } layer_state_t;

    // per neuron multiply-accumulate control
    typedef enum logic [1:0] {
        N_IDLE,
        N_ACC,
        N_OUT
    } neuron_state_t;

endpackage

/* weight_store.sv */
module weight_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wr_en,
    input  nn_pkg::weight_addr_t                   wr_addr,
    input  nn_pkg::weight_t                        wr_data,
    input  logic                                   busy,
    output logic [nn_pkg::WEIGHT_BUS_SIZE-1:0]     weights
);

    import nn_pkg::*;

    weight_t [NUM_WEIGHTS-1:0] weight_reg;                  // element 0 sits in the low bits
    logic    [NUM_WEIGHTS-1:0] wr_sel;                      // one-hot write decode
    logic                      addr_ok;
    logic                      wr_allowed;

    assign addr_ok    = (wr_addr < NUM_WEIGHTS);            // addresses 20..31 are not mapped
    assign wr_allowed = wr_en && !busy;                     // weights stay frozen during a run

    // address decode into a one-hot register select
    always_comb begin
        wr_sel = '0;
        if (wr_allowed && addr_ok) begin
            wr_sel[wr_addr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            weight_reg <= '0;
        end else begin
            for (int i = 0; i < NUM_WEIGHTS; i++) begin
                if (wr_sel[i]) begin
                    weight_reg[i] <= wr_data;
                end
            end
        end
    end

    // neuron n finds its weights at bits n*NEURON_WEIGHT_BITS upward
    assign weights = weight_reg;

endmodule

/* neuron.sv */
module neuron (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  nn_pkg::input_t  [nn_pkg::NUM_INPUTS-1:0] inputs,
    input  nn_pkg::weight_t [nn_pkg::NUM_INPUTS-1:0] weights,
    output nn_pkg::out_t                           out_value,
    output logic                                   out_valid
);

    import nn_pkg::*;

    neuron_state_t state;
    input_idx_t    idx;                                     // input taken in this cycle
    acc_t          acc;                                     // running weighted sum
    input_t        in_sel;
    weight_t       w_sel;
    acc_t          product;
    acc_t          shifted;
    out_t          sat_value;

    // operand select for the current step
    assign in_sel = inputs[idx];
    assign w_sel  = weights[idx];

    // both operands are signed and get extended to the accumulator width first
    assign product = in_sel * w_sel;

    // rescale to the output fraction, then clamp to the signed output range
    always_comb begin
        shifted = acc >>> SHIFT;                            // floors toward minus infinity
        if (shifted > OUT_MAX) begin
            sat_value = out_t'(OUT_MAX);
        end else if (shifted < OUT_MIN) begin
            sat_value = out_t'(OUT_MIN);
        end else begin
            sat_value = out_t'(shifted);
        end
    end

    // control path
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= N_IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
            out_value <= '0;
        end else if (start) begin
            state     <= N_ACC;                             // a new run restarts from input 0
            idx       <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                N_IDLE: begin
                    idx <= '0;
                end
                N_ACC: begin
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX) begin
                        state <= N_OUT;
                    end
                end
                N_OUT: begin
                    out_value <= sat_value;
                    out_valid <= 1'b1;                      // holds until the next start
                    state     <= N_IDLE;
                end
                default: begin
                    state <= N_IDLE;
                end
            endcase
        end
    end

    // accumulator datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (state == N_ACC) begin
            acc <= acc + product;
        end
    end

endmodule

/* layer.sv */
module layer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  nn_pkg::neuron_mask_t                   active,
    input  nn_pkg::input_t [nn_pkg::NUM_INPUTS-1:0] inputs,
    input  logic [nn_pkg::WEIGHT_BUS_SIZE-1:0]     weights,
    output nn_pkg::out_t   [nn_pkg::NUM_NEURON-1:0] out_values,
    output nn_pkg::neuron_mask_t                   out_valid,
    output logic                                   busy
);

    import nn_pkg::*;

    layer_state_t              state;
    logic                      internal_start;              // one cycle pulse into the neurons
    neuron_mask_t              active_q;                    // mask captured at start
    neuron_mask_t              neuron_valid;
    out_t [NUM_NEURON-1:0]     values;
    logic                      run_done;

    for (genvar i = 0; i < NUM_NEURON; i++) begin : g_neuron
        neuron i_neuron (
            .clk       (clk),
            .rst       (rst),
            .start     (internal_start & active_q[i]),
            .inputs    (inputs),
            .weights   (weights[i*NEURON_WEIGHT_BITS +: NEURON_WEIGHT_BITS]),
            .out_value (values[i]),
            .out_valid (neuron_valid[i])
        );
    end

    // neurons outside the captured mask count as finished
    assign run_done = &(neuron_valid | ~active_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= L_IDLE;
            internal_start <= 1'b0;
            active_q       <= '0;
        end else begin
            internal_start <= 1'b0;
            case (state)
                L_IDLE: begin
                    if (start) begin
                        state          <= L_RUN;
                        internal_start <= 1'b1;
                        active_q       <= active;       // later mask changes do not affect this run
                    end
                end
                L_RUN: begin
                    state <= L_DONE;                        // neurons drop out_valid on this edge
                end
                L_DONE: begin
                    if (run_done) begin
                        state <= L_IDLE;
                    end
                end
                default: begin
                    state <= L_IDLE;
                end
            endcase
        end
    end

    assign busy = (state != L_IDLE);

    // output register, the results reach the pins one cycle after the neurons
    always_ff @(posedge clk) begin
        if (rst) begin
            out_values <= '0;
            out_valid  <= '0;
        end else begin
            out_values <= values;
            out_valid  <= neuron_valid;
        end
    end

endmodule

/* nn_layer_top.sv */
module nn_layer_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wr_en,
    input  nn_pkg::weight_addr_t                   wr_addr,
    input  nn_pkg::weight_t                        wr_data,
    input  logic                                   start,
    input  nn_pkg::neuron_mask_t                   active,
    input  nn_pkg::input_t [nn_pkg::NUM_INPUTS-1:0] inputs,
    output nn_pkg::out_t   [nn_pkg::NUM_NEURON-1:0] out_values,
    output nn_pkg::neuron_mask_t                   out_valid,
    output logic                                   busy
);

    import nn_pkg::*;

    logic [WEIGHT_BUS_SIZE-1:0] weights;                    // all 20 weights, flat

    weight_store i_weight_store (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .busy    (busy),
        .weights (weights)
    );

    layer i_layer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .active     (active),
        .inputs     (inputs),
        .weights    (weights),
        .out_values (out_values),
        .out_valid  (out_valid),
        .busy       (busy)
    );

endmodule

/* tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_mismatch(input string name, input string what, input int exp,
                               input int act);
    errors++;
    $display("ERR %s: %s expected %0d actual %0d", name, what, exp, act);
endtask

// compares every neuron's value and valid flag with the model
task automatic check_outputs(input string name);
    for (int n = 0; n < NUM_NEURON; n++) begin
        if (out_valid[n] !== exp_valid[n]) begin
            report_mismatch(name, $sformatf("neuron %0d valid", n), int'(exp_valid[n]),
                            int'(out_valid[n]));
        end
        if (out_values[n] !== exp_value[n]) begin
            report_mismatch(name, $sformatf("neuron %0d value", n), int'(exp_value[n]),
                            int'(out_values[n]));
        end
    end
endtask

// one write strobe that leaves the model alone
task automatic write_weight(input int addr, input weight_t data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= weight_addr_t'(addr);
    wr_data <= data;
    @(posedge clk);
    wr_en   <= 1'b0;
endtask

task automatic load_weight(input int addr, input weight_t data);
    write_weight(addr, data);
    if (addr < NUM_WEIGHTS) begin
        weight_model[addr] = data;                          // unmapped addresses change nothing
    end
endtask

task automatic load_random_weights();
    for (int a = 0; a < NUM_WEIGHTS; a++) begin
        load_weight(a, weight_t'(int'($urandom % 1024) - 512)); // most sums stay in range
    end
endtask

task automatic apply_inputs();
    @(posedge clk);
    for (int k = 0; k < NUM_INPUTS; k++) begin
        inputs[k] <= input_model[k];
    end
endtask

task automatic random_inputs();
    for (int k = 0; k < NUM_INPUTS; k++) begin
        input_model[k] = input_t'($urandom);
    end
    apply_inputs();
endtask

// pulses start with a mask and follows the run until busy drops
task automatic run_layer(input string name, input neuron_mask_t mask, output int valid_cycle);
    int  cycle;
    int  busy_cycles;
    int  exp_busy;
    bit  finished;
    bit  seen_low;
    cycle       = 0;
    busy_cycles = 0;
    finished    = 1'b0;
    seen_low    = 1'b0;
    valid_cycle = -1;
    exp_busy    = (mask == '0) ? IDLE_RUN_BUSY : RUN_LATENCY;
    @(posedge clk);
    start  <= 1'b1;
    active <= mask;
    @(posedge clk);                                         // this edge samples start
    start  <= 1'b0;
    active <= ~mask;                                        // the captured mask must hold
    while (!finished && cycle < RUN_LIMIT) begin
        @(negedge clk);
        if (busy) begin
            busy_cycles++;
        end else begin
            finished = 1'b1;
        end
        if ((out_valid & mask) != mask) begin
            seen_low = 1'b1;
        end else if (seen_low && valid_cycle < 0) begin
            valid_cycle = cycle;
        end
        cycle++;
    end
    if (!finished) begin
        errors++;
        $display("%s: busy was still high %0d cycles after start", name, RUN_LIMIT);
    end
    if (busy_cycles != exp_busy) begin
        report_mismatch(name, "busy cycles", exp_busy, busy_cycles);
    end
    for (int n = 0; n < NUM_NEURON; n++) begin
        if (mask[n]) begin
            exp_value[n] = out_t'(ref_neuron(n));
            exp_valid[n] = 1'b1;
        end
    end
endtask

task automatic check_reset_state();
    tests_run++;
    @(negedge clk);
    if (busy !== 1'b0) begin
        report_mismatch("reset", "busy", 0, int'(busy));
    end
    check_outputs("reset");
endtask

task automatic full_layer_run();
    int valid_cycle;
    tests_run++;
    load_random_weights();
    random_inputs();
    run_layer("full_run", '1, valid_cycle);
    if (valid_cycle != RUN_LATENCY) begin
        report_mismatch("full_run", "out_valid latency", RUN_LATENCY, valid_cycle);
    end
    check_outputs("full_run");
    @(negedge clk);
    if (busy !== 1'b0) begin
        report_mismatch("full_run", "busy after run", 0, int'(busy));
    end
endtask

// neurons left out of a run keep their old results
task automatic masked_run();
    int valid_cycle;
    tests_run++;
    random_inputs();
    run_layer("mask", '1, valid_cycle);
    check_outputs("mask");
    random_inputs();
    run_layer("mask", 4'b0101, valid_cycle);
    check_outputs("mask");
    random_inputs();
    run_layer("mask", '0, valid_cycle);                     // an empty mask leaves all neurons
    check_outputs("mask");
endtask

task automatic saturation_cases();
    int      valid_cycle;
    int      sat_expect [NUM_NEURON];
    weight_t w;
    tests_run++;
    sat_expect[0] = 511;                                    // largest positive products
    sat_expect[1] = -512;                                   // largest negative products
    sat_expect[2] = -1;                                     // -255 / 512 floors to -1
    sat_expect[3] = -299;                                   // -153000 / 512 floors to -299
    for (int k = 0; k < NUM_INPUTS; k++) begin
        input_model[k] = input_t'(255);
    end
    apply_inputs();
    for (int n = 0; n < NUM_NEURON; n++) begin
        for (int k = 0; k < NUM_INPUTS; k++) begin
            case (n)
                0: w = weight_t'(65535);
                1: w = weight_t'(-65536);
                2: w = (k == 0) ? weight_t'(-1) : '0;
                default: w = (k == 0) ? weight_t'(-600) : '0;
            endcase
            load_weight(n * NUM_INPUTS + k, w);
        end
    end
    run_layer("saturation", '1, valid_cycle);
    check_outputs("saturation");
    for (int n = 0; n < NUM_NEURON; n++) begin
        if (int'(out_values[n]) != sat_expect[n]) begin
            report_mismatch("saturation", $sformatf("neuron %0d value", n), sat_expect[n],
                            int'(out_values[n]));
        end
    end
endtask

// start pulses and weight writes during a run have no effect
task automatic busy_protection();
    int valid_cycle;
    tests_run++;
    load_random_weights();
    random_inputs();
    fork
        run_layer("busy_guard", '1, valid_cycle);
        begin
            repeat (4) @(posedge clk);
            start <= 1'b1;                                  // lands while the layer is busy
            @(posedge clk);
            start <= 1'b0;
        end
    join
    check_outputs("busy_guard");
    repeat (4) begin
        @(negedge clk);
        if (busy) begin
            errors++;
            $display("busy_guard: busy rose again after the run, the extra start was taken");
        end
    end
    fork
        run_layer("busy_guard", '1, valid_cycle);
        begin
            repeat (3) @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= '0;
            wr_data <= ~weight_model[0];
            @(posedge clk);
            wr_en   <= 1'b0;
        end
    join
    check_outputs("busy_guard");
    run_layer("busy_guard", '1, valid_cycle);               // still the old weight 0
    check_outputs("busy_guard");
    load_weight(25, weight_t'($urandom));
    run_layer("busy_guard", '1, valid_cycle);
    check_outputs("busy_guard");
endtask

`endif

/* tb_nn_layer_top.sv */
module tb_nn_layer_top;

    timeunit 1ns;
    timeprecision 100ps;

    import nn_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_TEST = 200;                   // watchdog budget for each test
    localparam int RUN_LATENCY     = NUM_INPUTS + 3;        // start edge to out_valid rising
    localparam int IDLE_RUN_BUSY   = 2;                     // busy samples of an empty-mask run
    localparam int RUN_LIMIT       = 100;                   // cycles one run may take at most
    localparam int SAT_HI          = 511;
    localparam int SAT_LO          = -512;
    localparam int RESCALE         = 9;                     // 8 + 8 fraction bits down to 7

    logic                          clk;
    logic                          rst;
    logic                          wr_en;
    weight_addr_t                  wr_addr;
    weight_t                       wr_data;
    logic                          start;
    neuron_mask_t                  active;
    input_t [NUM_INPUTS-1:0]       inputs;
    out_t   [NUM_NEURON-1:0]       out_values;
    neuron_mask_t                  out_valid;
    logic                          busy;

    // reference model of what the DUT should hold
    weight_t weight_model [NUM_WEIGHTS];
    input_t  input_model  [NUM_INPUTS];
    out_t    exp_value    [NUM_NEURON];
    logic    exp_valid    [NUM_NEURON];

    int errors;
    int tests_run;

    nn_layer_top i_nn_layer_top (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .start      (start),
        .active     (active),
        .inputs     (inputs),
        .out_values (out_values),
        .out_valid  (out_valid),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                              // 8 ns period
    end

    // signed sum of products, arithmetic shift right, then clamp to 10 bits
    function automatic int ref_neuron(input int n);
        longint sum;
        longint scaled;
        sum = 0;
        for (int k = 0; k < NUM_INPUTS; k++) begin
            sum += longint'(input_model[k]) * longint'(weight_model[n * NUM_INPUTS + k]);
        end
        scaled = sum >>> RESCALE;                           // floor division by 512
        if (scaled > SAT_HI) begin
            return SAT_HI;
        end else if (scaled < SAT_LO) begin
            return SAT_LO;
        end
        return int'(scaled);
    endfunction

    `include "tb_tasks.svh"

    // watchdog sized from the number of tests
    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles, %0d errors so far",
                 RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'h279e_c5a4));
        errors    = 0;
        tests_run = 0;
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        start     = 1'b0;
        active    = '0;
        inputs    = '0;
        for (int a = 0; a < NUM_WEIGHTS; a++) begin
            weight_model[a] = '0;                           // weights clear at reset
        end
        for (int k = 0; k < NUM_INPUTS; k++) begin
            input_model[k] = '0;
        end
        for (int n = 0; n < NUM_NEURON; n++) begin
            exp_value[n] = '0;
            exp_valid[n] = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        full_layer_run();
        masked_run();
        saturation_cases();
        busy_protection();

        $display("summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* nn_layer_top.f */
+incdir+.
nn_pkg.sv
weight_store.sv
neuron.sv
layer.sv
nn_layer_top.sv
tb_nn_layer_top.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f nn_layer_top.f --top-module tb_nn_layer_top \
    && ./obj_dir/Vtb_nn_layer_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation result: failed"; exit 1; } \
    || { echo "simulation result: passed"; exit 0; }
